// File: design/cycle_game_top.sv
`default_nettype none
`timescale 1ns/1ps

module cycle_game_top import cycle_pkg::*; (
    input  logic          Clk,
    input  logic          reset,
    input  logic          frame_tick,
    input  logic          key_valid,
    input  logic [7:0]    keycode,
    output game_state_t   game_state,
    output cell_pos_t     blue_pos,
    output cell_pos_t     red_pos,
    output logic [1:0]    score_blue,
    output logic [1:0]    score_red,
    output round_result_t round_result
);

    key_cmd_t key_cmd;
    move_t    move;
    crash_t   crash;
    logic     clear_done;
    logic     game_won;

    // ----------------------------------------------------------
    // Pipeline, keys to motion to trail check
    // ----------------------------------------------------------
    key_decoder key_decoder_i (
        .Clk        (Clk),
        .reset      (reset),
        .key_valid  (key_valid),
        .keycode    (keycode),
        .frame_tick (frame_tick),
        .game_state (game_state),
        .key_cmd    (key_cmd)
    );

    rider_motion rider_motion_i (
        .Clk(Clk), .reset(reset), .frame_tick(frame_tick), .game_state(game_state),
        .key_cmd(key_cmd), .move(move), .blue_pos(blue_pos), .red_pos(red_pos)
    );

    trail_map trail_map_i (
        .Clk(Clk), .reset(reset), .game_state(game_state), .move(move),
        .crash(crash), .clear_done(clear_done)
    );

    // Control and scoring
    game_fsm game_fsm_i (
        .Clk(Clk), .reset(reset), .key_cmd(key_cmd), .clear_done(clear_done),
        .crash(crash), .game_won(game_won), .game_state(game_state)
    );

    score_keeper score_keeper_i (
        .Clk(Clk), .reset(reset), .game_state(game_state), .crash(crash),
        .score_blue(score_blue), .score_red(score_red),
        .round_result(round_result), .game_won(game_won)
    );

endmodule

`default_nettype wire

// File: design/cycle_params.svh
`ifndef CYCLE_PARAMS_SVH
`define CYCLE_PARAMS_SVH

// Arena size in cells
`define GRID_W       32
`define GRID_H       24
`define CELL_COUNT   (`GRID_W * `GRID_H)

// Start cells, riders face each other across the middle row
`define BLUE_START_X 8
`define BLUE_START_Y 12
`define RED_START_X  23
`define RED_START_Y  12

`define WIN_SCORE    3       // Round wins that take the game

// USB HID usage codes
`define KEY_W        8'h1A   // Blue up
`define KEY_A        8'h04   // Blue left
`define KEY_S        8'h16   // Blue down
`define KEY_D        8'h07   // Blue right
`define KEY_UP       8'h52   // Red up
`define KEY_LEFT     8'h50   // Red left
`define KEY_DOWN     8'h51   // Red down
`define KEY_RIGHT    8'h4F   // Red right
`define KEY_SPACE    8'h2C   // Start round or game

`endif

// File: design/cycle_pkg.sv
`default_nettype none

package cycle_pkg;

    // Heading, opposite direction differs in bit 1
    typedef enum logic [1:0] {
        UP    = 2'd0,
        RIGHT = 2'd1,
        DOWN  = 2'd2,
        LEFT  = 2'd3
    } dir_t;

    typedef struct packed {
        logic [4:0] x;
        logic [4:0] y;
    } cell_pos_t;

    typedef struct packed {
        cell_pos_t pos;
        dir_t      dir;
        logic      off_grid;   // Stepped past an edge
    } rider_t;

    typedef struct packed {
        logic valid;
        dir_t dir;
    } turn_t;

    typedef struct packed {
        logic  start;          // Space key pulse
        turn_t blue;
        turn_t red;
    } key_cmd_t;

    typedef struct packed {
        logic   valid;
        rider_t blue;
        rider_t red;
    } move_t;

    typedef struct packed {
        logic valid;
        logic blue_crash;
        logic red_crash;
    } crash_t;

    typedef enum logic [2:0] {IDLE, CLEAR, RUN, ROUND_END, GAME_OVER} game_state_t;

    typedef enum logic [1:0] {NONE, BLUE_WINS, RED_WINS, DRAW} round_result_t;

endpackage

`default_nettype wire

// File: design/game_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module game_fsm import cycle_pkg::*; (
    input  logic        Clk,
    input  logic        reset,
    input  key_cmd_t    key_cmd,
    input  logic        clear_done,
    input  crash_t      crash,
    input  logic        game_won,
    output game_state_t game_state
);

    game_state_t state_q, state_d;
    logic        any_crash;

    assign any_crash = crash.valid && (crash.blue_crash || crash.red_crash);

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (key_cmd.start) state_d = CLEAR;
            end
            CLEAR: begin
                if (clear_done) state_d = RUN;   // Grid ready, riders parked
            end
            RUN: begin
                if (any_crash) state_d = ROUND_END;
            end
            ROUND_END: begin
                // Winner check first, scores land the same cycle we enter
                if (game_won)           state_d = GAME_OVER;
                else if (key_cmd.start) state_d = CLEAR;
            end
            GAME_OVER: begin
                if (key_cmd.start) state_d = CLEAR;   // Scores cleared in score_keeper
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) state_q <= IDLE;
        else       state_q <= state_d;
    end

    assign game_state = state_q;

    // Three bit encoding has three unused codes
    a_legal_state: assert property (@(posedge Clk) disable iff (reset)
        game_state inside {IDLE, CLEAR, RUN, ROUND_END, GAME_OVER})
        else $error("game_state holds illegal code %0h", game_state);

endmodule

`default_nettype wire

// File: design/key_decoder.sv
`default_nettype none
`timescale 1ns/1ps
`include "cycle_params.svh"

module key_decoder import cycle_pkg::*; (
    input  logic        Clk,
    input  logic        reset,
    input  logic        key_valid,
    input  logic [7:0]  keycode,
    input  logic        frame_tick,
    input  game_state_t game_state,
    output key_cmd_t    key_cmd
);

    turn_t blue_key, red_key;      // Decoded this cycle
    turn_t blue_pend, red_pend;    // Latest turn waiting for a tick
    logic  start_q;
    logic  consume;

    // Steering keys, anything else decodes to no turn
    always_comb begin
        blue_key = '0;
        red_key  = '0;
        if (key_valid) begin
            case (keycode)
                `KEY_W:     blue_key = '{valid: 1'b1, dir: UP};
                `KEY_A:     blue_key = '{valid: 1'b1, dir: LEFT};
                `KEY_S:     blue_key = '{valid: 1'b1, dir: DOWN};
                `KEY_D:     blue_key = '{valid: 1'b1, dir: RIGHT};
                `KEY_UP:    red_key  = '{valid: 1'b1, dir: UP};
                `KEY_LEFT:  red_key  = '{valid: 1'b1, dir: LEFT};
                `KEY_DOWN:  red_key  = '{valid: 1'b1, dir: DOWN};
                `KEY_RIGHT: red_key  = '{valid: 1'b1, dir: RIGHT};
                default: ;
            endcase
        end
    end

    assign consume = frame_tick || (game_state != RUN);  // Tick uses it, or not playing

    always_ff @(posedge Clk) begin
        if (reset) begin
            blue_pend <= '0;
            red_pend  <= '0;
            start_q   <= 1'b0;
        end else begin
            start_q <= key_valid && (keycode == `KEY_SPACE);
            // New key wins over consumption, only while running
            if (blue_key.valid && game_state == RUN) blue_pend <= blue_key;
            else if (consume)                        blue_pend <= '0;
            if (red_key.valid && game_state == RUN)  red_pend  <= red_key;
            else if (consume)                        red_pend  <= '0;
        end
    end

    assign key_cmd = '{start: start_q, blue: blue_pend, red: red_pend};

endmodule

`default_nettype wire

// File: design/rider_motion.sv
`default_nettype none
`timescale 1ns/1ps
`include "cycle_params.svh"

module rider_motion import cycle_pkg::*; (
    input  logic        Clk,
    input  logic        reset,
    input  logic        frame_tick,
    input  game_state_t game_state,
    input  key_cmd_t    key_cmd,
    output move_t       move,
    output cell_pos_t   blue_pos,
    output cell_pos_t   red_pos
);

    localparam rider_t BLUE_HOME = '{
        pos: '{x: 5'(`BLUE_START_X), y: 5'(`BLUE_START_Y)}, dir: RIGHT, off_grid: 1'b0};
    localparam rider_t RED_HOME = '{
        pos: '{x: 5'(`RED_START_X), y: 5'(`RED_START_Y)}, dir: LEFT, off_grid: 1'b0};

    rider_t blue_r, red_r;
    logic   move_valid;

    // ----------------------------------------------------------
    // One frame step of a rider
    // ----------------------------------------------------------
    function automatic rider_t step_rider(rider_t cur, turn_t turn);
        rider_t nxt;
        nxt = cur;
        // Reversal would be instant self crash, so drop it
        if (turn.valid && (turn.dir != dir_t'(cur.dir ^ 2'd2)))
            nxt.dir = turn.dir;
        case (nxt.dir)
            UP: begin
                if (cur.pos.y == 5'd0) nxt.off_grid = 1'b1;   // Hold the edge cell
                else nxt.pos.y = cur.pos.y - 5'd1;
            end
            DOWN: begin
                if (cur.pos.y == 5'(`GRID_H - 1)) nxt.off_grid = 1'b1;
                else nxt.pos.y = cur.pos.y + 5'd1;
            end
            LEFT: begin
                if (cur.pos.x == 5'd0) nxt.off_grid = 1'b1;
                else nxt.pos.x = cur.pos.x - 5'd1;
            end
            default: begin   // RIGHT
                if (cur.pos.x == 5'(`GRID_W - 1)) nxt.off_grid = 1'b1;
                else nxt.pos.x = cur.pos.x + 5'd1;
            end
        endcase
        return nxt;
    endfunction

    always_ff @(posedge Clk) begin
        if (reset) begin
            blue_r     <= BLUE_HOME;
            red_r      <= RED_HOME;
            move_valid <= 1'b0;
        end else begin
            move_valid <= 1'b0;
            if (game_state == CLEAR) begin   // Park at start while the grid clears
                blue_r <= BLUE_HOME;
                red_r  <= RED_HOME;
            end else if (game_state == RUN && frame_tick) begin
                blue_r     <= step_rider(blue_r, key_cmd.blue);
                red_r      <= step_rider(red_r, key_cmd.red);
                move_valid <= 1'b1;
            end
        end
    end

    assign move     = '{valid: move_valid, blue: blue_r, red: red_r};
    assign blue_pos = blue_r.pos;
    assign red_pos  = red_r.pos;

    // Pipeline holds one move per stage only with this spacing
    a_tick_spacing: assert property (@(posedge Clk) disable iff (reset)
        frame_tick |=> !frame_tick [*3])
        else $error("frame_tick less than four cycles after the last one");

endmodule

`default_nettype wire

// File: design/score_keeper.sv
`default_nettype none
`timescale 1ns/1ps
`include "cycle_params.svh"

module score_keeper import cycle_pkg::*; (
    input  logic          Clk,
    input  logic          reset,
    input  game_state_t   game_state,
    input  crash_t        crash,
    output logic [1:0]    score_blue,
    output logic [1:0]    score_red,
    output round_result_t round_result,
    output logic          game_won
);

    localparam logic [1:0] WIN = 2'(`WIN_SCORE);

    assign game_won = (score_blue == WIN) || (score_red == WIN);

    always_ff @(posedge Clk) begin
        if (reset) begin
            score_blue   <= 2'd0;
            score_red    <= 2'd0;
            round_result <= NONE;
        end else if (game_state == CLEAR) begin
            round_result <= NONE;
            if (game_won) begin   // Only reachable from GAME_OVER
                score_blue <= 2'd0;
                score_red  <= 2'd0;
            end
        end else if (game_state == RUN && crash.valid) begin
            case ({crash.blue_crash, crash.red_crash})
                2'b11: round_result <= DRAW;   // No credit
                2'b10: begin
                    round_result <= RED_WINS;
                    score_red    <= score_red + 2'd1;
                end
                2'b01: begin
                    round_result <= BLUE_WINS;
                    score_blue   <= score_blue + 2'd1;
                end
                default: ;   // Clean frame
            endcase
        end
    end

    // A round scored with a score already at WIN would wrap past WIN_SCORE
    a_score_cap: assert property (@(posedge Clk) disable iff (reset)
        (game_state == RUN && crash.valid) |-> !game_won)
        else $error("crash scored with a score at WIN_SCORE, blue %0h red %0h",
                    score_blue, score_red);

endmodule

`default_nettype wire

// File: design/trail_map.sv
`default_nettype none
`timescale 1ns/1ps
`include "cycle_params.svh"

module trail_map import cycle_pkg::*; (
    input  logic        Clk,
    input  logic        reset,
    input  game_state_t game_state,
    input  move_t       move,
    output crash_t      crash,
    output logic        clear_done
);

    localparam int ADDR_W = $clog2(`CELL_COUNT);

    // Owner codes per cell
    localparam logic [1:0] OWN_EMPTY = 2'd0;
    localparam logic [1:0] OWN_BLUE  = 2'd1;
    localparam logic [1:0] OWN_RED   = 2'd2;

    localparam int BLUE_HOME_ADDR = `BLUE_START_Y * `GRID_W + `BLUE_START_X;
    localparam int RED_HOME_ADDR  = `RED_START_Y * `GRID_W + `RED_START_X;

    logic [1:0]        grid_mem [`CELL_COUNT];
    logic [ADDR_W:0]   clr_idx;              // One extra bit to reach CELL_COUNT
    logic [ADDR_W-1:0] blue_addr, red_addr;
    logic              same_cell;
    logic              blue_hit, red_hit;

    function automatic logic [ADDR_W-1:0] cell_addr(cell_pos_t p);
        return ADDR_W'(p.y * `GRID_W + p.x);   // Row major
    endfunction

    // ----------------------------------------------------------
    // Head check, async read of both new heads
    // ----------------------------------------------------------
    always_comb begin
        blue_addr = cell_addr(move.blue.pos);
        red_addr  = cell_addr(move.red.pos);
        same_cell = (move.blue.pos == move.red.pos);   // Head on, both go down
        blue_hit  = move.blue.off_grid || (grid_mem[blue_addr] != OWN_EMPTY) || same_cell;
        red_hit   = move.red.off_grid || (grid_mem[red_addr] != OWN_EMPTY) || same_cell;
    end

    // Clear walk or trail writes
    always_ff @(posedge Clk) begin
        if (game_state == CLEAR && clr_idx < `CELL_COUNT) begin
            if (clr_idx == BLUE_HOME_ADDR)
                grid_mem[clr_idx[ADDR_W-1:0]] <= OWN_BLUE;
            else if (clr_idx == RED_HOME_ADDR)
                grid_mem[clr_idx[ADDR_W-1:0]] <= OWN_RED;
            else
                grid_mem[clr_idx[ADDR_W-1:0]] <= OWN_EMPTY;
        end else if (move.valid) begin
            if (!blue_hit) grid_mem[blue_addr] <= OWN_BLUE;   // Survivors only
            if (!red_hit)  grid_mem[red_addr]  <= OWN_RED;
        end
    end

    // ----------------------------------------------------------
    // Control, crash report and clear counter
    // ----------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (reset) begin
            clr_idx    <= '0;
            clear_done <= 1'b0;
            crash      <= '0;
        end else begin
            crash      <= '0;
            clear_done <= 1'b0;
            if (move.valid)
                crash <= '{valid: 1'b1, blue_crash: blue_hit, red_crash: red_hit};
            if (game_state != CLEAR) begin
                clr_idx <= '0;
            end else if (clr_idx < `CELL_COUNT) begin
                clr_idx    <= clr_idx + 1'b1;
                clear_done <= (clr_idx == `CELL_COUNT - 1);   // Pulse after last write
            end
        end
    end

    // Motion only steps in RUN, so nothing may land on a clearing grid
    a_no_move_in_clear: assert property (@(posedge Clk) disable iff (reset)
        !(move.valid && game_state == CLEAR))
        else $error("move arrived while the grid was clearing");

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/cycle_pkg.sv
design/key_decoder.sv
design/rider_motion.sv
design/trail_map.sv
design/game_fsm.sv
design/score_keeper.sv
design/cycle_game_top.sv
tests/tb_cycle_game.sv

// File: tests/tb_cycle_game.sv
`default_nettype none
`timescale 1ns/1ps
`include "cycle_params.svh"

module tb_cycle_game import cycle_pkg::*; ();

    logic          Clk = 1'b0;
    logic          reset, frame_tick, key_valid;
    logic [7:0]    keycode;
    game_state_t   game_state;
    cell_pos_t     blue_pos, red_pos;
    logic [1:0]    score_blue, score_red;
    round_result_t round_result;

    // Model of the arena with one bit per occupied cell
    logic [`GRID_W-1:0] m_grid [`GRID_H];
    int            bx, by, rx, ry;
    dir_t          bdir, rdir;
    logic          boff, roff;
    turn_t         bpend, rpend;           // Latest steering key per player
    int            sb, sr;
    round_result_t m_result;

    // Blue keys at 0..3 and red keys at 4..7, low two bits in dir_t order
    logic [7:0] steer_keys [8] = '{`KEY_W, `KEY_D, `KEY_S, `KEY_A,
                                   `KEY_UP, `KEY_RIGHT, `KEY_DOWN, `KEY_LEFT};
    integer seed = 14;
    int     errors, rounds, frames, e0, sb0, sr0, wall_hits, trail_hits;
    logic   crashed;

    cycle_game_top cycle_game_top_i (
        .Clk(Clk), .reset(reset), .frame_tick(frame_tick), .key_valid(key_valid),
        .keycode(keycode), .game_state(game_state), .blue_pos(blue_pos), .red_pos(red_pos),
        .score_blue(score_blue), .score_red(score_red), .round_result(round_result)
    );

    always #5 Clk = ~Clk;   // 100 MHz

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic wait_state(input game_state_t want, input int limit);
        int n;
        n = 0;
        while (game_state !== want && n < limit) begin
            @(negedge Clk);
            n++;
        end
        if (game_state !== want) begin
            errors++;
            $display("Timed out after %0d cycles waiting for state %0d", limit, want);
        end
    endtask

    task automatic press_key(input logic [7:0] code);
        @(negedge Clk);
        key_valid = 1'b1;
        keycode   = code;
        @(negedge Clk);
        key_valid = 1'b0;
    endtask

    // ----------------------------------------------------------
    // Game rules
    // ----------------------------------------------------------
    task automatic step_model(inout int x, inout int y, inout dir_t d, inout logic off,
                              input turn_t t);
        int   nx, ny;
        dir_t rev;
        case (d)
            UP:      rev = DOWN;
            DOWN:    rev = UP;
            LEFT:    rev = RIGHT;
            default: rev = LEFT;
        endcase
        if (t.valid && t.dir != rev) d = t.dir;   // U-turns dropped
        nx = x + ((d == RIGHT) ? 1 : (d == LEFT) ? -1 : 0);
        ny = y + ((d == DOWN) ? 1 : (d == UP) ? -1 : 0);
        if (nx < 0 || nx >= `GRID_W || ny < 0 || ny >= `GRID_H) off = 1'b1;   // Stays on edge
        else begin
            x = nx;
            y = ny;
        end
    endtask

    task automatic new_round_model();
        if (sb == `WIN_SCORE || sr == `WIN_SCORE) begin   // New game
            sb = 0;
            sr = 0;
        end
        foreach (m_grid[i]) m_grid[i] = '0;
        bx = `BLUE_START_X;
        by = `BLUE_START_Y;
        rx = `RED_START_X;
        ry = `RED_START_Y;
        bdir = RIGHT;
        rdir = LEFT;
        boff = 1'b0;
        roff = 1'b0;
        bpend = '0;
        rpend = '0;
        m_grid[by][bx] = 1'b1;
        m_grid[ry][rx] = 1'b1;
        m_result = NONE;
        if (round_result !== NONE) mismatch("round_result", round_result, NONE);
        if (score_blue !== sb) mismatch("score_blue", score_blue, sb);
        if (score_red !== sr) mismatch("score_red", score_red, sr);
    endtask

    task automatic start_round();
        press_key(`KEY_SPACE);
        wait_state(RUN, `CELL_COUNT + 20);
        new_round_model();
    endtask

    // One 6 cycle frame with an optional early key and the tick in the last cycle
    task automatic run_frame(input logic steer, output logic hit);
        logic [31:0] r;
        logic [2:0]  k;
        logic        bc, rc, same;
        @(negedge Clk);
        r = $random(seed);
        if (steer && r[1:0] == 2'd0) begin   // About one key in four frames
            k = r[4:2];
            key_valid = 1'b1;
            keycode   = steer_keys[k];
            if (k < 4) bpend = '{valid: 1'b1, dir: dir_t'(k[1:0])};
            else rpend = '{valid: 1'b1, dir: dir_t'(k[1:0])};
        end
        @(negedge Clk);
        key_valid = 1'b0;
        repeat (3) @(negedge Clk);
        if (game_state !== RUN) mismatch("game_state", game_state, RUN);
        frame_tick = 1'b1;
        step_model(bx, by, bdir, boff, bpend);
        step_model(rx, ry, rdir, roff, rpend);
        bpend = '0;
        rpend = '0;
        same = (bx == rx) && (by == ry);
        bc = boff || m_grid[by][bx] || same;   // Heads read before any write
        rc = roff || m_grid[ry][rx] || same;
        if (!bc) m_grid[by][bx] = 1'b1;
        if (!rc) m_grid[ry][rx] = 1'b1;
        frames++;
        @(negedge Clk);
        frame_tick = 1'b0;
        if (blue_pos.x !== 5'(bx) || blue_pos.y !== 5'(by))
            mismatch("blue_pos", blue_pos, {5'(bx), 5'(by)});
        if (red_pos.x !== 5'(rx) || red_pos.y !== 5'(ry))
            mismatch("red_pos", red_pos, {5'(rx), 5'(ry)});
        hit = bc || rc;
        if (hit) begin
            wall_hits  += (boff || roff);
            trail_hits += !(boff || roff);
            if (bc && rc) m_result = DRAW;
            else if (bc) begin
                m_result = RED_WINS;
                sr++;
            end else begin
                m_result = BLUE_WINS;
                sb++;
            end
            @(negedge Clk);
            if (game_state !== RUN) mismatch("game_state", game_state, RUN);
            @(negedge Clk);   // Third cycle after the tick
            if (game_state !== ROUND_END) mismatch("game_state", game_state, ROUND_END);
            if (round_result !== m_result) mismatch("round_result", round_result, m_result);
            if (score_blue !== sb) mismatch("score_blue", score_blue, sb);
            if (score_red !== sr) mismatch("score_red", score_red, sr);
        end
    endtask

    task automatic play_round(input int max_frames, input logic steer, output logic hit);
        int n;
        hit = 1'b0;
        n = 0;
        while (!hit && n < max_frames) begin
            run_frame(steer, hit);
            n++;
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        reset = 1'b1;
        frame_tick = 1'b0;
        key_valid = 1'b0;
        keycode = 8'h00;
        errors = 0;
        rounds = 0;
        frames = 0;
        wall_hits = 0;
        trail_hits = 0;
        sb = 0;
        sr = 0;
        repeat (3) @(negedge Clk);
        reset = 1'b0;
        @(negedge Clk);

        e0 = errors;
        if (game_state !== IDLE) mismatch("game_state", game_state, IDLE);
        new_round_model();   // Start cells, zero scores, no result
        if (blue_pos !== cell_pos_t'{x: 5'(bx), y: 5'(by)})
            mismatch("blue_pos", blue_pos, {5'(bx), 5'(by)});
        if (red_pos !== cell_pos_t'{x: 5'(rx), y: 5'(ry)})
            mismatch("red_pos", red_pos, {5'(rx), 5'(ry)});
        $display("Test 1 reset state: %0d errors", errors - e0);

        e0 = errors;
        start_round();
        play_round(20, 1'b1, crashed);
        $display("Test 2 random steering, %0d frames: %0d errors", frames, errors - e0);

        e0 = errors;
        if (!crashed) play_round(800, 1'b1, crashed);
        rounds++;
        while (crashed && sb < 2 && sr < 2 && rounds < 4) begin   // Keep clear of game over
            start_round();
            play_round(800, 1'b1, crashed);
            rounds++;
        end
        if (!crashed) begin
            errors++;
            $display("A random round ran 800 frames without a crash");
        end
        $display("Test 3 random rounds, %0d wall and %0d trail crashes: %0d errors",
                 wall_hits, trail_hits, errors - e0);

        e0 = errors;
        start_round();
        sb0 = sb;
        sr0 = sr;
        play_round(20, 1'b0, crashed);   // Straight at each other
        rounds++;
        if (!crashed) begin
            errors++;
            $display("Riders on a head-on course never crashed");
        end
        if (round_result !== DRAW) mismatch("round_result", round_result, DRAW);
        if (score_blue !== sb0) mismatch("score_blue", score_blue, sb0);
        if (score_red !== sr0) mismatch("score_red", score_red, sr0);
        $display("Test 4 head-on draw: %0d errors", errors - e0);

        e0 = errors;
        while (crashed && sb < `WIN_SCORE && sr < `WIN_SCORE && rounds < 40) begin
            start_round();
            play_round(800, 1'b1, crashed);
            rounds++;
        end
        if (!crashed) begin
            errors++;
            $display("A round before game over ran 800 frames without a crash");
        end
        wait_state(GAME_OVER, 5);
        press_key(`KEY_W);   // Ignored outside RUN
        press_key(`KEY_SPACE);
        wait_state(CLEAR, 5);
        repeat (2) @(negedge Clk);
        if (score_blue !== 2'd0) mismatch("score_blue", score_blue, 0);
        if (score_red !== 2'd0) mismatch("score_red", score_red, 0);
        press_key(`KEY_DOWN);   // Red turn during clear
        press_key(`KEY_S);
        wait_state(RUN, `CELL_COUNT + 20);
        new_round_model();
        run_frame(1'b0, crashed);   // First move must go straight
        $display("Test 5 game over and restart: %0d errors", errors - e0);

        $display("Tests 5, rounds %0d, frames %0d, errors %0d", rounds, frames, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
